//--- accel_wrap.f
+incdir+common
common/accel_pkg.sv
logic/accel_regs.sv
dma/accel_rd_dma.sv
logic/line_fifo.sv
match/byte_matcher.sv
logic/accel_wrap.sv
sim/accel_wrap_chk.sv
sim/accel_wrap_tb.sv

//--- common/accel_pkg.sv
`default_nettype none

`include "accel_settings.svh"

package accel_pkg;

  // Opcode in CTRL bits 1:0
  typedef enum logic [1:0] {
    CMD_NOP   = 2'd0,
    CMD_START = 2'd1,
    CMD_STOP  = 2'd2,
    CMD_INIT  = 2'd3
  } acc_cmd_e;

  typedef struct packed {
    logic [`ACC_MEM_ADDR_W-1:0] addr;
    logic [`ACC_LEN_W-1:0]      len;
  } acc_desc_t;

  // Byte 0 of data sits in bits 7:0 and comes first in the stream
  typedef struct packed {
    logic                                spare;
    logic                                last;
    logic [$clog2(`ACC_LINE_BYTES)-1:0]  nbytes;
    logic [`ACC_LINE_W-1:0]              data;
  } acc_line_t;

  // Byte 0 of bytes is the first pattern byte
  typedef struct packed {
    logic [`ACC_PAT_MAX*8-1:0]           bytes;
    logic [$clog2(`ACC_PAT_MAX+1)-1:0]   len;
  } acc_pattern_t;

  // pos is the index of the byte that completed the hit
  typedef struct packed {
    logic                  hit;
    logic                  done;
    logic [`ACC_LEN_W-1:0] pos;
  } acc_result_t;

  typedef enum logic [1:0] {
    DMA_IDLE = 2'd0,
    DMA_READ = 2'd1,
    DMA_WAIT = 2'd2
  } acc_dma_state_e;

endpackage

`default_nettype wire

//--- common/accel_settings.svh
`ifndef ACCEL_SETTINGS_SVH
`define ACCEL_SETTINGS_SVH

// Packet memory line geometry
`define ACC_LINE_BYTES 8
`define ACC_LINE_W 64
`define ACC_MEM_ADDR_W 8

// Packet length in bytes
`define ACC_LEN_W 12

// Host register port
`define ACC_IO_ADDR_W 8
`define ACC_IO_DATA_W 32

`define ACC_FIFO_DEPTH 4

// Longest search pattern in bytes
`define ACC_PAT_MAX 4

`endif

//--- dma/accel_rd_dma.sv
`timescale 1ns/1ps
`default_nettype none

`include "accel_settings.svh"

module accel_rd_dma (
  input  wire                          clk,
  input  wire                          rst,
  input  wire accel_pkg::acc_desc_t    desc,
  input  wire                          desc_valid,
  input  wire                          stop,
  output logic                         mem_en,
  output logic [`ACC_MEM_ADDR_W-1:0]   mem_addr,
  input  wire [`ACC_LINE_W-1:0]        mem_rd_data,
  input  wire                          fifo_space,
  output accel_pkg::acc_line_t         wr_line,
  output logic                         wr_en
);
  import accel_pkg::*;

  localparam int NB_W = $clog2(`ACC_LINE_BYTES);
  localparam logic [`ACC_LEN_W-1:0] LINE_BYTES = `ACC_LINE_BYTES;

  acc_dma_state_e        state;
  logic [`ACC_LEN_W-1:0] bytes_left;
  logic [`ACC_LEN_W-1:0] bytes_m1;
  logic                  last_line;
  logic                  rd_pending;
  logic [NB_W-1:0]       pend_nbytes;
  logic                  pend_last;

  assign bytes_m1  = bytes_left - 1'b1;
  assign last_line = bytes_left <= LINE_BYTES;

  // FIFO space already accounts for the read still in flight
  assign mem_en = (state == DMA_READ) && fifo_space && !stop;

  always_ff @(posedge clk) begin
    rd_pending <= mem_en;

    case (state)
      DMA_IDLE: begin
        if (desc_valid) begin
          mem_addr   <= desc.addr;
          bytes_left <= desc.len;
          state      <= DMA_READ;
        end
      end
      DMA_READ: begin
        if (mem_en) begin
          mem_addr  <= mem_addr + 1'b1;
          pend_last <= last_line;
          if (last_line) begin
            // Final line may be partial
            pend_nbytes <= bytes_m1[NB_W-1:0];
            state       <= DMA_WAIT;
          end else begin
            pend_nbytes <= '1;
            bytes_left  <= bytes_left - LINE_BYTES;
          end
        end
      end
      DMA_WAIT: begin
        // Last line lands in the FIFO this cycle
        state <= DMA_IDLE;
      end
      default: state <= DMA_IDLE;
    endcase

    if (stop) begin
      state <= DMA_IDLE;
    end

    if (rst) begin
      state      <= DMA_IDLE;
      rd_pending <= 1'b0;
    end
  end

  // Memory data arrives one cycle after mem_en
  assign wr_en          = rd_pending;
  assign wr_line.data   = mem_rd_data;
  assign wr_line.nbytes = pend_nbytes;
  assign wr_line.last   = pend_last;
  assign wr_line.spare  = 1'b0;

endmodule

`default_nettype wire

//--- logic/accel_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "accel_settings.svh"

module accel_regs (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           io_en,
  input  wire                           io_wen,
  input  wire [`ACC_IO_DATA_W/8-1:0]    io_strb,
  input  wire [`ACC_IO_ADDR_W-1:0]      io_addr,
  input  wire [`ACC_IO_DATA_W-1:0]      io_wr_data,
  output logic [`ACC_IO_DATA_W-1:0]     io_rd_data,
  output logic                          io_rd_valid,
  output accel_pkg::acc_desc_t          desc,
  output logic                          desc_valid,
  output logic                          start,
  output logic                          stop,
  output accel_pkg::acc_pattern_t       pattern,
  input  wire accel_pkg::acc_result_t   result
);
  import accel_pkg::*;

  localparam int PLEN_W = $clog2(`ACC_PAT_MAX + 1);

  localparam logic [`ACC_IO_ADDR_W-1:0] REG_CTRL      = 'h00;
  localparam logic [`ACC_IO_ADDR_W-1:0] REG_STATUS    = 'h00;
  localparam logic [`ACC_IO_ADDR_W-1:0] REG_LEN       = 'h04;
  localparam logic [`ACC_IO_ADDR_W-1:0] REG_ADDR      = 'h08;
  localparam logic [`ACC_IO_ADDR_W-1:0] REG_PATTERN   = 'h0C;
  localparam logic [`ACC_IO_ADDR_W-1:0] REG_MATCH_POS = 'h0C;
  localparam logic [`ACC_IO_ADDR_W-1:0] REG_PATLEN    = 'h10;
  localparam logic [`ACC_IO_ADDR_W-1:0] REG_MATCH_CNT = 'h10;
  localparam logic [`ACC_IO_ADDR_W-1:0] REG_DESC_ERR  = 'h14;

  logic [`ACC_LEN_W-1:0]      len_reg;
  logic [`ACC_MEM_ADDR_W-1:0] addr_reg;
  logic                       busy;
  logic                       done;
  logic                       match;
  logic                       desc_err;
  logic [`ACC_LEN_W-1:0]      first_pos;
  logic [`ACC_LEN_W-1:0]      match_cnt;
  logic                       rd_stall;
  logic                       wr_req;
  logic                       rd_req;
  logic [`ACC_IO_DATA_W-1:0]  wr_old;
  logic [`ACC_IO_DATA_W-1:0]  wr_val;
  acc_cmd_e                   cmd;

  function automatic logic [`ACC_IO_DATA_W-1:0] merge_strb(
    input logic [`ACC_IO_DATA_W-1:0]   old_val,
    input logic [`ACC_IO_DATA_W-1:0]   new_val,
    input logic [`ACC_IO_DATA_W/8-1:0] strb
  );
    logic [`ACC_IO_DATA_W-1:0] res;
    res = old_val;
    for (int b = 0; b < `ACC_IO_DATA_W/8; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = new_val[b*8 +: 8];
      end
    end
    return res;
  endfunction

  assign wr_req = io_en && io_wen;
  // Host holds the address while a read is stalled
  assign rd_req = (io_en && !io_wen) || rd_stall;
  assign cmd    = acc_cmd_e'(io_wr_data[1:0]);

  // Current value of the addressed register for byte strobes
  always_comb begin
    wr_old = '0;
    case (io_addr)
      REG_LEN:     wr_old[`ACC_LEN_W-1:0] = len_reg;
      REG_ADDR:    wr_old[`ACC_MEM_ADDR_W-1:0] = addr_reg;
      REG_PATTERN: wr_old = pattern.bytes;
      REG_PATLEN:  wr_old[PLEN_W-1:0] = pattern.len;
      default:     ;
    endcase
  end

  assign wr_val = merge_strb(wr_old, io_wr_data, io_strb);

  always_ff @(posedge clk) begin
    desc_valid  <= 1'b0;
    start       <= 1'b0;
    stop        <= 1'b0;
    io_rd_valid <= 1'b0;

    if (busy) begin
      if (result.hit) begin
        match_cnt <= match_cnt + 1'b1;
        if (!match) begin
          match     <= 1'b1;
          first_pos <= result.pos;
        end
      end
      if (result.done) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end

    if (wr_req) begin
      case (io_addr)
        REG_CTRL: begin
          if (io_strb[0]) begin
            case (cmd)
              CMD_START: begin
                if (busy || len_reg == '0) begin
                  desc_err <= 1'b1;
                end else begin
                  busy       <= 1'b1;
                  done       <= 1'b0;
                  match      <= 1'b0;
                  match_cnt  <= '0;
                  first_pos  <= '0;
                  desc.addr  <= addr_reg;
                  desc.len   <= len_reg;
                  desc_valid <= 1'b1;
                  start      <= 1'b1;
                end
              end
              CMD_STOP: begin
                done <= 1'b1;
                busy <= 1'b0;
                stop <= 1'b1;
              end
              CMD_INIT: begin
                done      <= 1'b0;
                match     <= 1'b0;
                match_cnt <= '0;
                desc_err  <= 1'b0;
              end
              default: ;
            endcase
          end
        end
        REG_LEN:     len_reg <= wr_val[`ACC_LEN_W-1:0];
        REG_ADDR:    addr_reg <= wr_val[`ACC_MEM_ADDR_W-1:0];
        REG_PATTERN: pattern.bytes <= wr_val;
        REG_PATLEN:  pattern.len <= wr_val[PLEN_W-1:0];
        default:     ;
      endcase
    end

    if (rd_req) begin
      io_rd_valid <= 1'b1;
      io_rd_data  <= '0;
      case (io_addr)
        REG_STATUS: begin
          io_rd_data[1] <= busy;
          io_rd_data[8] <= done;
          io_rd_data[9] <= match;
        end
        REG_LEN:  io_rd_data[`ACC_LEN_W-1:0] <= len_reg;
        REG_ADDR: io_rd_data[`ACC_MEM_ADDR_W-1:0] <= addr_reg;
        REG_MATCH_POS: begin
          if (match) begin
            io_rd_data[`ACC_LEN_W-1:0] <= first_pos;
          end else begin
            io_rd_data <= '1;
          end
          // Answer waits for the end of the run or the first hit
          io_rd_valid <= done || match;
          rd_stall    <= !(done || match);
        end
        REG_MATCH_CNT: io_rd_data[`ACC_LEN_W-1:0] <= match_cnt;
        REG_DESC_ERR:  io_rd_data[0] <= desc_err;
        default: ;
      endcase
    end

    if (rst) begin
      busy        <= 1'b0;
      done        <= 1'b0;
      match       <= 1'b0;
      match_cnt   <= '0;
      desc_err    <= 1'b0;
      desc_valid  <= 1'b0;
      start       <= 1'b0;
      stop        <= 1'b0;
      io_rd_valid <= 1'b0;
      rd_stall    <= 1'b0;
      len_reg     <= '0;
      addr_reg    <= '0;
      pattern.len <= '0;
    end
  end

endmodule

`default_nettype wire

//--- logic/accel_wrap.sv
`timescale 1ns/1ps
`default_nettype none

`include "accel_settings.svh"

module accel_wrap (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         io_en,
  input  wire                         io_wen,
  input  wire [`ACC_IO_DATA_W/8-1:0]  io_strb,
  input  wire [`ACC_IO_ADDR_W-1:0]    io_addr,
  input  wire [`ACC_IO_DATA_W-1:0]    io_wr_data,
  output wire [`ACC_IO_DATA_W-1:0]    io_rd_data,
  output wire                         io_rd_valid,
  output wire                         mem_en,
  output wire [`ACC_MEM_ADDR_W-1:0]   mem_addr,
  input  wire [`ACC_LINE_W-1:0]       mem_rd_data
);
  import accel_pkg::*;

  acc_desc_t    desc;
  logic         desc_valid;
  logic         start;
  logic         stop;
  acc_pattern_t pattern;
  acc_result_t  result;
  logic         fifo_space;
  acc_line_t    wr_line;
  logic         wr_en;
  acc_line_t    rd_line;
  logic         fifo_empty;
  logic         pop;

  accel_regs accel_regs_inst (
    .clk(clk),
    .rst(rst),
    .io_en(io_en),
    .io_wen(io_wen),
    .io_strb(io_strb),
    .io_addr(io_addr),
    .io_wr_data(io_wr_data),
    .io_rd_data(io_rd_data),
    .io_rd_valid(io_rd_valid),
    .desc(desc),
    .desc_valid(desc_valid),
    .start(start),
    .stop(stop),
    .pattern(pattern),
    .result(result)
  );

  accel_rd_dma accel_rd_dma_inst (
    .clk(clk),
    .rst(rst),
    .desc(desc),
    .desc_valid(desc_valid),
    .stop(stop),
    .mem_en(mem_en),
    .mem_addr(mem_addr),
    .mem_rd_data(mem_rd_data),
    .fifo_space(fifo_space),
    .wr_line(wr_line),
    .wr_en(wr_en)
  );

  line_fifo line_fifo_inst (
    .clk(clk),
    .rst(rst),
    .stop(stop),
    .wr_line(wr_line),
    .wr_en(wr_en),
    .fifo_space(fifo_space),
    .rd_line(rd_line),
    .empty(fifo_empty),
    .pop(pop)
  );

  byte_matcher byte_matcher_inst (
    .clk(clk),
    .rst(rst),
    .start(start),
    .stop(stop),
    .pattern(pattern),
    .rd_line(rd_line),
    .empty(fifo_empty),
    .pop(pop),
    .result(result)
  );

endmodule

`default_nettype wire

//--- logic/line_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "accel_settings.svh"

module line_fifo (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         stop,
  input  wire accel_pkg::acc_line_t   wr_line,
  input  wire                         wr_en,
  output logic                        fifo_space,
  output accel_pkg::acc_line_t        rd_line,
  output logic                        empty,
  input  wire                         pop
);
  import accel_pkg::*;

  localparam int DEPTH = `ACC_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  acc_line_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_pop;

  assign empty   = count == '0;
  assign do_pop  = pop && !empty;
  // Show-ahead head
  assign rd_line = mem[rd_ptr];

  // Keep a slot for the line already requested from memory
  assign fifo_space = (count + CNT_W'(wr_en)) < CNT_W'(DEPTH);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_line;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
    if (do_pop) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
    count <= count + CNT_W'(wr_en) - CNT_W'(do_pop);

    // Stop drops everything buffered
    if (rst || stop) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
  end

endmodule

`default_nettype wire

//--- match/byte_matcher.sv
`timescale 1ns/1ps
`default_nettype none

`include "accel_settings.svh"

module byte_matcher (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           start,
  input  wire                           stop,
  input  wire accel_pkg::acc_pattern_t  pattern,
  input  wire accel_pkg::acc_line_t     rd_line,
  input  wire                           empty,
  output logic                          pop,
  output accel_pkg::acc_result_t        result
);
  import accel_pkg::*;

  localparam int NB_W   = $clog2(`ACC_LINE_BYTES);
  localparam int WIN_W  = `ACC_PAT_MAX * 8;
  localparam int FILL_W = $clog2(`ACC_PAT_MAX + 1);

  logic [NB_W-1:0]       byte_idx;
  logic [`ACC_LEN_W-1:0] pos;
  logic [WIN_W-1:0]      window;
  logic [WIN_W-1:0]      next_win;
  logic [FILL_W-1:0]     fill;
  logic [7:0]            cur_byte;
  logic                  take;
  logic                  line_end;
  logic                  win_hit;

  assign take     = !empty && !stop;
  assign line_end = byte_idx == rd_line.nbytes;
  assign pop      = take && line_end;
  assign cur_byte = rd_line.data[byte_idx*8 +: 8];
  // Newest byte in the low lane
  assign next_win = {window[WIN_W-9:0], cur_byte};

  // Oldest window byte of the compare lines up with pattern byte 0
  always_comb begin
    win_hit = (pattern.len != '0) && (pattern.len <= `ACC_PAT_MAX)
              && (fill >= pattern.len - 1'b1);
    for (int j = 0; j < `ACC_PAT_MAX; j++) begin
      if (j < int'(pattern.len)) begin
        if (next_win[j*8 +: 8] != pattern.bytes[(int'(pattern.len) - 1 - j)*8 +: 8]) begin
          win_hit = 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    result.hit  <= 1'b0;
    result.done <= 1'b0;

    if (take) begin
      window   <= next_win;
      pos      <= pos + 1'b1;
      byte_idx <= line_end ? '0 : byte_idx + 1'b1;
      if (fill != FILL_W'(`ACC_PAT_MAX)) begin
        fill <= fill + 1'b1;
      end
      result.hit  <= win_hit;
      result.done <= line_end && rd_line.last;
      result.pos  <= pos;
    end

    if (start || stop) begin
      window   <= '0;
      fill     <= '0;
      byte_idx <= '0;
      pos      <= '0;
    end

    if (rst) begin
      result.hit  <= 1'b0;
      result.done <= 1'b0;
      fill        <= '0;
      byte_idx    <= '0;
      pos         <= '0;
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the accel_wrap testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module accel_wrap_tb -f accel_wrap.f --Mdir obj_dir \
  && ./obj_dir/Vaccel_wrap_tb \
  || { echo "Simulation run failed"; exit 1; }

//--- sim/accel_wrap_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "accel_settings.svh"

module accel_wrap_chk (
  input wire clk,
  input wire rst,
  input wire io_en,
  input wire io_wen,
  input wire io_rd_valid,
  input wire mem_en,
  input wire wr_en,
  input wire pop,
  input wire fifo_empty,
  input wire stop
);

  localparam int CNT_W = $clog2(`ACC_FIFO_DEPTH + 1);

  logic             rd_open;
  logic [CNT_W-1:0] occ;

  // Open from the read strobe until its answer
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_open <= 1'b0;
    end else if (io_en && !io_wen) begin
      rd_open <= 1'b1;
    end else if (io_rd_valid) begin
      rd_open <= 1'b0;
    end
  end

  // Shadow of the FIFO fill level
  always_ff @(posedge clk) begin
    if (rst || stop) begin
      occ <= '0;
    end else begin
      occ <= occ + CNT_W'(wr_en) - CNT_W'(pop && !fifo_empty);
    end
  end

  a_rd_valid_open: assert property (@(posedge clk) disable iff (rst) io_rd_valid |-> rd_open)
    else $error("io_rd_valid without an open read");

  // Stored lines plus the line landing now must leave room for a new read
  a_mem_en_space: assert property (@(posedge clk) disable iff (rst)
    mem_en |-> ((occ + CNT_W'(wr_en)) < CNT_W'(`ACC_FIFO_DEPTH)))
    else $error("mem_en high while the FIFO has no space");

  a_fifo_overflow: assert property (@(posedge clk) disable iff (rst)
    (wr_en && !stop) |-> (occ < CNT_W'(`ACC_FIFO_DEPTH)))
    else $error("line written into a full FIFO");

  a_quiet_reset: assert property (@(posedge clk) rst |=> (!io_rd_valid && !mem_en))
    else $error("io_rd_valid or mem_en high right after reset");

endmodule

bind accel_wrap accel_wrap_chk accel_wrap_chk_inst (
  .clk(clk),
  .rst(rst),
  .io_en(io_en),
  .io_wen(io_wen),
  .io_rd_valid(io_rd_valid),
  .mem_en(mem_en),
  .wr_en(wr_en),
  .pop(pop),
  .fifo_empty(fifo_empty),
  .stop(stop)
);

`default_nettype wire

//--- sim/accel_wrap_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "accel_settings.svh"

module accel_wrap_tb;
  import accel_pkg::*;

  localparam int MEM_BYTES  = (1 << `ACC_MEM_ADDR_W) * `ACC_LINE_BYTES;
  localparam int RD_TIMEOUT = 4000;
  localparam int DONE_TRIES = 300;

  localparam logic [`ACC_IO_ADDR_W-1:0] REG_CTRL        = 8'h00;
  localparam logic [`ACC_IO_ADDR_W-1:0] REG_STATUS      = 8'h00;
  localparam logic [`ACC_IO_ADDR_W-1:0] REG_LEN         = 8'h04;
  localparam logic [`ACC_IO_ADDR_W-1:0] REG_ADDR        = 8'h08;
  localparam logic [`ACC_IO_ADDR_W-1:0] REG_PATTERN     = 8'h0C;
  localparam logic [`ACC_IO_ADDR_W-1:0] REG_MATCH_POS   = 8'h0C;
  localparam logic [`ACC_IO_ADDR_W-1:0] REG_PATLEN      = 8'h10;
  localparam logic [`ACC_IO_ADDR_W-1:0] REG_MATCH_COUNT = 8'h10;
  localparam logic [`ACC_IO_ADDR_W-1:0] REG_DESC_ERR    = 8'h14;

  logic                         clk;
  logic                         rst;
  logic                         io_en;
  logic                         io_wen;
  logic [`ACC_IO_DATA_W/8-1:0]  io_strb;
  logic [`ACC_IO_ADDR_W-1:0]    io_addr;
  logic [`ACC_IO_DATA_W-1:0]    io_wr_data;
  wire  [`ACC_IO_DATA_W-1:0]    io_rd_data;
  wire                          io_rd_valid;
  wire                          mem_en;
  wire  [`ACC_MEM_ADDR_W-1:0]   mem_addr;
  logic [`ACC_LINE_W-1:0]       mem_rd_data;

  logic [7:0] pkt_mem [MEM_BYTES];
  logic [7:0] pat [`ACC_PAT_MAX];
  int         pat_len;
  int         exp_first;
  int         exp_count;

  accel_wrap accel_wrap_inst (
    .clk(clk),
    .rst(rst),
    .io_en(io_en),
    .io_wen(io_wen),
    .io_strb(io_strb),
    .io_addr(io_addr),
    .io_wr_data(io_wr_data),
    .io_rd_data(io_rd_data),
    .io_rd_valid(io_rd_valid),
    .mem_en(mem_en),
    .mem_addr(mem_addr),
    .mem_rd_data(mem_rd_data)
  );

  always #2 clk = ~clk;

  // Synchronous packet memory with byte 0 of a line in bits 7:0
  always @(posedge clk) begin
    if (mem_en) begin
      for (int k = 0; k < `ACC_LINE_BYTES; k++) begin
        mem_rd_data[k*8 +: 8] <= pkt_mem[int'(mem_addr) * `ACC_LINE_BYTES + k];
      end
    end
  end

  task automatic stop_with(input string line);
    $display("%s", line);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic write_reg(input logic [`ACC_IO_ADDR_W-1:0] addr, input logic [31:0] data);
    @(negedge clk);
    io_en      = 1'b1;
    io_wen     = 1'b1;
    io_addr    = addr;
    io_wr_data = data;
    io_strb    = '1;
    @(negedge clk);
    io_en  = 1'b0;
    io_wen = 1'b0;
  endtask

  // Address stays put until the answer since a stalled read needs it
  task automatic read_reg(input logic [`ACC_IO_ADDR_W-1:0] addr, output logic [31:0] data);
    int waited;
    waited = 0;
    @(negedge clk);
    io_en   = 1'b1;
    io_wen  = 1'b0;
    io_strb = '0;
    io_addr = addr;
    @(negedge clk);
    io_en = 1'b0;
    while (!io_rd_valid) begin
      if (waited == RD_TIMEOUT) begin
        stop_with("Timed out waiting for the answer to a register read");
      end else begin
        waited++;
        @(negedge clk);
      end
    end
    data = io_rd_data;
  endtask

  task automatic check_masked(input logic [`ACC_IO_ADDR_W-1:0] addr, input logic [31:0] mask,
                              input logic [31:0] exp, input string what);
    logic [31:0] got;
    read_reg(addr, got);
    assert ((got & mask) == exp) else
      stop_with($sformatf("ERROR %0t: %s read 0x%08h, expected 0x%08h under mask 0x%08h",
                          $time, what, got, exp, mask));
  endtask

  task automatic check_read(input logic [`ACC_IO_ADDR_W-1:0] addr, input logic [31:0] exp,
                            input string what);
    check_masked(addr, '1, exp, what);
  endtask

  task automatic wait_done();
    logic [31:0] status;
    int          tries;
    tries = 0;
    read_reg(REG_STATUS, status);
    while (!status[8]) begin
      if (tries == DONE_TRIES) begin
        stop_with("Timed out waiting for the run to finish");
      end else begin
        tries++;
        read_reg(REG_STATUS, status);
      end
    end
  endtask

  task automatic load_pattern(input logic [31:0] word, input int len);
    for (int j = 0; j < `ACC_PAT_MAX; j++) begin
      pat[j] = word[j*8 +: 8];
    end
    pat_len = len;
    write_reg(REG_PATTERN, word);
    write_reg(REG_PATLEN, 32'(len));
  endtask

  // Every window that ends at byte i and equals the pattern is a hit at i
  task automatic model_run(input int line_addr, input int len);
    int base;
    bit same;
    base      = line_addr * `ACC_LINE_BYTES;
    exp_first = -1;
    exp_count = 0;
    for (int i = pat_len - 1; i < len; i++) begin
      same = 1'b1;
      for (int j = 0; j < pat_len; j++) begin
        if (pkt_mem[base + i - pat_len + 1 + j] != pat[j]) begin
          same = 1'b0;
        end
      end
      if (same) begin
        if (exp_first < 0) begin
          exp_first = i;
        end
        exp_count++;
      end
    end
  endtask

  task automatic run_packet(input int line_addr, input int len);
    logic [31:0] exp_pos;
    write_reg(REG_LEN, 32'(len));
    write_reg(REG_ADDR, 32'(line_addr));
    check_read(REG_LEN, 32'(len), "LEN");
    check_read(REG_ADDR, 32'(line_addr), "ADDR");
    model_run(line_addr, len);
    exp_pos = (exp_first < 0) ? '1 : 32'(exp_first);
    write_reg(REG_CTRL, 32'(CMD_START));
    check_read(REG_MATCH_POS, exp_pos, "MATCH_POS");
    if (exp_first < 0) begin
      // A miss answers only once the run is over
      check_masked(REG_STATUS, 32'h100, 32'h100, "STATUS done at MATCH_POS answer");
    end
    wait_done();
    check_read(REG_MATCH_COUNT, 32'(exp_count), "MATCH_COUNT");
    check_read(REG_STATUS, (exp_count > 0) ? 32'h300 : 32'h100, "STATUS after run");
  endtask

  task automatic plant(input int byte_addr, input int n);
    for (int k = 0; k < n; k++) begin
      pkt_mem[byte_addr + k] = 8'hA5;
    end
  endtask

  initial begin
    logic [7:0] b;
    clk         = 1'b0;
    rst         = 1'b1;
    io_en       = 1'b0;
    io_wen      = 1'b0;
    io_strb     = '0;
    io_addr     = '0;
    io_wr_data  = '0;
    mem_rd_data = '0;
    void'($urandom(32'h4507));

    // Random data that never holds 0xA5
    for (int a = 0; a < MEM_BYTES; a++) begin
      b = 8'($urandom);
      if (b == 8'hA5) begin
        b = 8'h5A;
      end
      pkt_mem[a] = b;
    end
    // Overlapping run across a line edge, a short run, and a run cut by LEN
    plant(86, 5);
    plant(110, 3);
    plant(120, 2);
    plant(123, 4);
    // Mixed pattern with two overlapping hits
    pkt_mem[163] = 8'hA5;
    pkt_mem[164] = 8'h3C;
    pkt_mem[165] = 8'hA5;
    pkt_mem[166] = 8'h3C;
    pkt_mem[167] = 8'hA5;
    // Single bytes for the long packet with the last one past its end
    plant(480, 1);
    plant(557, 1);
    plant(630, 1);
    plant(682, 1);
    plant(685, 1);

    repeat (5) @(negedge clk);
    rst = 1'b0;

    repeat (4) begin
      @(negedge clk);
      assert (!io_rd_valid) else
        stop_with($sformatf("ERROR %0t: io_rd_valid high with no read", $time));
    end
    check_read(REG_STATUS, 32'h0, "STATUS after reset");
    check_read(REG_MATCH_COUNT, 32'h0, "MATCH_COUNT after reset");
    check_read(REG_DESC_ERR, 32'h0, "DESC_ERR after reset");

    load_pattern(32'h00A5A5A5, 3);
    run_packet(10, 45);
    load_pattern(32'h00A53CA5, 3);
    run_packet(20, 24);

    // No pattern in this packet
    load_pattern(32'h00A5A5A5, 3);
    run_packet(40, 64);

    // About 200 bytes with a partial last line
    load_pattern(32'h000000A5, 1);
    run_packet(60, 203);

    write_reg(REG_LEN, 32'd203);
    write_reg(REG_ADDR, 32'd100);
    write_reg(REG_CTRL, 32'(CMD_START));
    write_reg(REG_CTRL, 32'(CMD_START));
    check_masked(REG_STATUS, 32'h2, 32'h2, "STATUS busy");
    check_read(REG_DESC_ERR, 32'h1, "DESC_ERR after START while busy");
    write_reg(REG_CTRL, 32'(CMD_STOP));
    check_masked(REG_STATUS, 32'h102, 32'h100, "STATUS after STOP");
    write_reg(REG_CTRL, 32'(CMD_INIT));
    check_read(REG_STATUS, 32'h0, "STATUS after INIT");
    check_read(REG_DESC_ERR, 32'h0, "DESC_ERR after INIT");
    check_read(REG_MATCH_COUNT, 32'h0, "MATCH_COUNT after INIT");

    write_reg(REG_LEN, 32'd0);
    write_reg(REG_CTRL, 32'(CMD_START));
    check_read(REG_DESC_ERR, 32'h1, "DESC_ERR after START with zero LEN");
    check_read(REG_STATUS, 32'h0, "STATUS after START with zero LEN");
    write_reg(REG_CTRL, 32'(CMD_INIT));
    check_read(REG_DESC_ERR, 32'h0, "DESC_ERR after second INIT");

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire
